/* bench/rename_trace.txt */
# T name | D rs1 rs2 rd we prs1 prs2 prd old_prd rdy1 rdy2 gl_index | N rs1 rs2 rd we
# W v0 idx0 prd0 v1 idx1 prd1 | I cycles | F full | C rd prd gl_index
T reset
F 0
D 1 2 3 1 1 2 32 3 1 1 0
D 3 0 4 1 32 0 33 4 0 1 1
T dependency
D 4 3 0 1 33 32 0 0 0 0 2
D 5 6 7 0 5 6 7 7 1 1 3
D 1 1 8 1 1 1 34 8 1 1 4
T writeback_ready
W 1 0 32 0 0 0
I 1
D 3 0 9 1 32 0 35 9 1 1 5
W 1 1 33 1 4 34
D 4 8 10 1 33 34 36 10 1 1 6
T in_order_commit
W 1 6 36 1 3 7
I 1
W 1 5 35 1 2 0
I 6
C 3 32 0
C 4 33 1
C 0 0 2
C 7 7 3
C 8 34 4
C 9 35 5
C 10 36 6
T full_list
D 0 0 11 1 0 0 37 11 1 1 7
D 0 0 12 1 0 0 38 12 1 1 8
D 0 0 13 1 0 0 39 13 1 1 9
D 0 0 14 1 0 0 40 14 1 1 10
D 0 0 15 1 0 0 41 15 1 1 11
D 0 0 16 1 0 0 42 16 1 1 12
D 0 0 17 1 0 0 43 17 1 1 13
D 0 0 18 1 0 0 44 18 1 1 14
D 0 0 19 1 0 0 45 19 1 1 15
D 0 0 20 1 0 0 46 20 1 1 0
D 0 0 21 1 0 0 47 21 1 1 1
D 0 0 22 1 0 0 48 22 1 1 2
D 0 0 23 1 0 0 49 23 1 1 3
D 0 0 24 1 0 0 50 24 1 1 4
D 0 0 25 1 0 0 51 25 1 1 5
D 0 0 26 1 0 0 52 26 1 1 6
F 1
N 0 0 27 1
W 1 7 37 0 0 0
I 1
F 1
I 1
F 0
C 11 37 7
T register_reuse
W 1 8 38 1 9 39
I 1
W 1 10 40 1 11 41
I 1
W 1 12 42 1 13 43
I 1
W 1 14 44 1 15 45
I 1
W 1 0 46 1 1 47
I 1
W 1 2 48 1 3 49
I 8
C 12 38 8
C 13 39 9
C 14 40 10
C 15 41 11
C 16 42 12
C 17 43 13
C 18 44 14
C 19 45 15
C 20 46 0
C 21 47 1
C 22 48 2
C 23 49 3
D 0 0 27 1 0 0 53 27 1 1 7
D 0 0 28 1 0 0 54 28 1 1 8
D 0 0 29 1 0 0 55 29 1 1 9
D 0 0 30 1 0 0 56 30 1 1 10
D 0 0 31 1 0 0 57 31 1 1 11
D 0 0 1 1 0 0 58 1 1 1 12
D 0 0 2 1 0 0 59 2 1 1 13
D 0 0 5 1 0 0 60 5 1 1 14
D 0 0 6 1 0 0 61 6 1 1 15
D 0 0 7 1 0 0 62 7 1 1 0
D 0 0 12 1 0 0 63 38 1 1 1
D 12 0 13 1 63 0 3 39 0 1 2
D 0 0 14 1 0 0 4 40 1 1 3

/* vlog.f */
+incdir+include
hw/rename_pkg.sv
hw/gl_alloc_if.sv
hw/free_list.sv
hw/rename_map.sv
hw/gl_slot.sv
hw/gl_commit.sv
hw/rename_core.sv
bench/rename_core_tb.sv

/* Makefile */
# Verilator regression for the rename block

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the trace regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/rename_core_tb.sv */
// Rename block testbench
`timescale 1ns/1ns
`include "rename_defines.svh"

module rename_core_tb import rename_pkg::*; ();

    localparam string TRACE_FILE        = "bench/rename_trace.txt";
    localparam int    CLK_PERIOD        = 10;
    localparam int    CYCLES_PER_RECORD = 20;
    localparam int    NUM_FIELDS        = 11;
    localparam int    DRAIN_CYCLES      = 40;

    typedef struct {
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      rdy1;
        logic      rdy2;
        gl_index_t idx;
        string     test;
    } rename_exp_t;

    typedef struct {
        arch_reg_t rd;
        phys_reg_t prd;
        gl_index_t idx;
        string     test;
    } commit_exp_t;

    logic                      clk_i;
    logic                      rstn_i;
    logic                      dispatch_valid_i;
    arch_reg_t                 dispatch_rs1_i;
    arch_reg_t                 dispatch_rs2_i;
    arch_reg_t                 dispatch_rd_i;
    logic                      dispatch_we_i;
    logic      [`WB_PORTS-1:0] wb_valid_i;
    gl_index_t [`WB_PORTS-1:0] wb_gl_index_i;
    phys_reg_t [`WB_PORTS-1:0] wb_prd_i;
    logic                      rename_valid_o;
    phys_reg_t                 rename_prs1_o;
    phys_reg_t                 rename_prs2_o;
    phys_reg_t                 rename_prd_o;
    phys_reg_t                 rename_old_prd_o;
    logic                      rename_rdy1_o;
    logic                      rename_rdy2_o;
    gl_index_t                 rename_gl_index_o;
    logic                      full_o;
    logic                      commit_valid_o;
    arch_reg_t                 commit_rd_o;
    phys_reg_t                 commit_prd_o;
    gl_index_t                 commit_gl_index_o;

    // Parsed trace with NUM_FIELDS integers per stored record
    byte         rec_kind[$];
    int          rec_fld[$];
    string       rec_test[$];
    int          total_records;
    rename_exp_t rename_q[$];
    commit_exp_t commit_q[$];
    int          mismatches;
    int          failures;

    rename_core i_rename_core (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////
    // Compare tasks

    task automatic check_phys(input string test, input string what,
                              input phys_reg_t exp, input phys_reg_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_index(input string test, input string what,
                               input gl_index_t exp, input gl_index_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_arch(input string test, input string what,
                              input arch_reg_t exp, input arch_reg_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    ////////////////////
    // Trace loading

    // Commit records go straight to the commit queue
    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        string       word;
        string       test;
        byte         kind;
        int          f [NUM_FIELDS];
        commit_exp_t c;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the trace file %s", TRACE_FILE);
            return;
        end
        test = "none";
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 1 || line[0] == "#") begin
                continue;
            end
            total_records++;
            kind = line[0];
            if (kind == "T") begin
                n = $sscanf(line, "T %s", word);
                test = word;
                continue;
            end
            foreach (f[k]) f[k] = 0;
            n = $sscanf(line, "%c %d %d %d %d %d %d %d %d %d %d %d", kind,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (kind == "C") begin
                c.rd   = arch_reg_t'(f[0]);
                c.prd  = phys_reg_t'(f[1]);
                c.idx  = gl_index_t'(f[2]);
                c.test = test;
                commit_q.push_back(c);
            end else begin
                rec_kind.push_back(kind);
                rec_test.push_back(test);
                for (int k = 0; k < NUM_FIELDS; k++) begin
                    rec_fld.push_back(f[k]);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////
    // Cycle stepping

    task automatic sample_outputs();
        rename_exp_t r;
        commit_exp_t c;
        if (rename_valid_o) begin
            if (rename_q.size() == 0) begin
                failures++;
                $display("Rename result appeared with no dispatch expecting one");
            end else begin
                r = rename_q.pop_front();
                check_phys(r.test, "prs1", r.prs1, rename_prs1_o);
                check_phys(r.test, "prs2", r.prs2, rename_prs2_o);
                check_phys(r.test, "prd", r.prd, rename_prd_o);
                check_phys(r.test, "old_prd", r.old_prd, rename_old_prd_o);
                check_flag(r.test, "rdy1", r.rdy1, rename_rdy1_o);
                check_flag(r.test, "rdy2", r.rdy2, rename_rdy2_o);
                check_index(r.test, "rename gl_index", r.idx, rename_gl_index_o);
            end
        end
        if (commit_valid_o) begin
            if (commit_q.size() == 0) begin
                failures++;
                $display("Commit of gl_index %0d was not expected", commit_gl_index_o);
            end else begin
                c = commit_q.pop_front();
                check_arch(c.test, "commit rd", c.rd, commit_rd_o);
                check_phys(c.test, "commit prd", c.prd, commit_prd_o);
                check_index(c.test, "commit gl_index", c.idx, commit_gl_index_o);
            end
        end
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic step();
        @(posedge clk_i);
        #1;
        sample_outputs();
        dispatch_valid_i = 1'b0;
        wb_valid_i       = '0;
    endtask

    task automatic drive_dispatch(input int base);
        dispatch_valid_i = 1'b1;
        dispatch_rs1_i   = arch_reg_t'(rec_fld[base]);
        dispatch_rs2_i   = arch_reg_t'(rec_fld[base + 1]);
        dispatch_rd_i    = arch_reg_t'(rec_fld[base + 2]);
        dispatch_we_i    = (rec_fld[base + 3] != 0);
    endtask

    task automatic run_record(input int i);
        int          base;
        rename_exp_t r;
        base = i * NUM_FIELDS;
        case (rec_kind[i])
            "D": begin
                drive_dispatch(base);
                r.prs1    = phys_reg_t'(rec_fld[base + 4]);
                r.prs2    = phys_reg_t'(rec_fld[base + 5]);
                r.prd     = phys_reg_t'(rec_fld[base + 6]);
                r.old_prd = phys_reg_t'(rec_fld[base + 7]);
                r.rdy1    = (rec_fld[base + 8] != 0);
                r.rdy2    = (rec_fld[base + 9] != 0);
                r.idx     = gl_index_t'(rec_fld[base + 10]);
                r.test    = rec_test[i];
                rename_q.push_back(r);
                step();
                // Registered result is due one cycle after the dispatch edge
                if (rename_q.size() != 0) begin
                    failures++;
                    $display("Rename result in test %s did not arrive one cycle after dispatch",
                             r.test);
                    rename_q.delete();
                end
            end
            "N": begin
                drive_dispatch(base);
                step();
            end
            // Held until the next record that advances the clock
            "W": begin
                for (int p = 0; p < `WB_PORTS; p++) begin
                    wb_valid_i[p]    = (rec_fld[base + 3 * p] != 0);
                    wb_gl_index_i[p] = gl_index_t'(rec_fld[base + 3 * p + 1]);
                    wb_prd_i[p]      = phys_reg_t'(rec_fld[base + 3 * p + 2]);
                end
            end
            "I": begin
                repeat (rec_fld[base]) step();
            end
            "F": begin
                check_flag(rec_test[i], "full_o", rec_fld[base] != 0, full_o);
            end
            default: begin
                failures++;
                $display("Trace record %0d has an unknown kind", i);
            end
        endcase
    endtask

    ////////////////////
    // Main sequence

    initial begin
        rstn_i           = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_rs1_i   = '0;
        dispatch_rs2_i   = '0;
        dispatch_rd_i    = '0;
        dispatch_we_i    = 1'b0;
        wb_valid_i       = '0;
        wb_gl_index_i    = '0;
        wb_prd_i         = '0;
        mismatches       = 0;
        failures         = 0;
        total_records    = 0;
        load_trace();
        fork
            begin
                #((total_records + 2) * CYCLES_PER_RECORD * CLK_PERIOD);
                $display("Watchdog expired before the trace finished");
                $display("Regression failed");
                $finish;
            end
        join_none
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        for (int i = 0; i < rec_kind.size(); i++) begin
            run_record(i);
        end
        // Let outstanding commits arrive
        for (int i = 0; i < DRAIN_CYCLES && commit_q.size() > 0; i++) begin
            step();
        end
        foreach (commit_q[k]) begin
            failures++;
            $display("Expected commit of rd %0d at gl_index %0d in test %s never arrived",
                     commit_q[k].rd, commit_q[k].idx, commit_q[k].test);
        end
        $display("Checks finished with %0d mismatches and %0d other errors",
                 mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* hw/rename_core.sv */
// Register rename and graduation list
`timescale 1ns/1ns
`include "rename_defines.svh"

module rename_core import rename_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // Dispatch
    input  logic                      dispatch_valid_i,
    input  arch_reg_t                 dispatch_rs1_i,
    input  arch_reg_t                 dispatch_rs2_i,
    input  arch_reg_t                 dispatch_rd_i,
    input  logic                      dispatch_we_i,
    // Writeback
    input  logic      [`WB_PORTS-1:0] wb_valid_i,
    input  gl_index_t [`WB_PORTS-1:0] wb_gl_index_i,
    input  phys_reg_t [`WB_PORTS-1:0] wb_prd_i,
    // Rename results
    output logic                      rename_valid_o,
    output phys_reg_t                 rename_prs1_o,
    output phys_reg_t                 rename_prs2_o,
    output phys_reg_t                 rename_prd_o,
    output phys_reg_t                 rename_old_prd_o,
    output logic                      rename_rdy1_o,
    output logic                      rename_rdy2_o,
    output gl_index_t                 rename_gl_index_o,
    output logic                      full_o,
    // Commit
    output logic                      commit_valid_o,
    output arch_reg_t                 commit_rd_o,
    output phys_reg_t                 commit_prd_o,
    output gl_index_t                 commit_gl_index_o
);

    gl_alloc_if alloc_bus ();

    gl_state_t [`GL_DEPTH-1:0] slot_state;
    logic                      retire;
    gl_index_t                 head;
    logic                      free_valid;
    phys_reg_t                 free_reg;

    rename_map i_rename_map (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dispatch_valid_i (dispatch_valid_i),
        .rs1_i            (dispatch_rs1_i),
        .rs2_i            (dispatch_rs2_i),
        .rd_i             (dispatch_rd_i),
        .we_i             (dispatch_we_i),
        .wb_valid_i       (wb_valid_i),
        .wb_prd_i         (wb_prd_i),
        .retire_i         (retire),
        .free_valid_i     (free_valid),
        .free_reg_i       (free_reg),
        .alloc            (alloc_bus.source),
        .rename_valid_o   (rename_valid_o),
        .prs1_o           (rename_prs1_o),
        .prs2_o           (rename_prs2_o),
        .prd_o            (rename_prd_o),
        .old_prd_o        (rename_old_prd_o),
        .rdy1_o           (rename_rdy1_o),
        .rdy2_o           (rename_rdy2_o),
        .gl_index_o       (rename_gl_index_o),
        .full_o           (full_o)
    );

    ////////////////////
    // Graduation slots

    for (genvar g = 0; g < `GL_DEPTH; g++) begin : g_slot
        gl_slot #(
            .SLOT_INDEX (g)
        ) i_gl_slot (
            .clk_i         (clk_i),
            .rstn_i        (rstn_i),
            .alloc         (alloc_bus.sink),
            .wb_valid_i    (wb_valid_i),
            .wb_gl_index_i (wb_gl_index_i),
            .retire_i      (retire),
            .head_i        (head),
            .state_o       (slot_state[g])
        );
    end

    gl_commit i_gl_commit (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .slots_i           (slot_state),
        .retire_o          (retire),
        .head_o            (head),
        .free_valid_o      (free_valid),
        .free_reg_o        (free_reg),
        .commit_valid_o    (commit_valid_o),
        .commit_rd_o       (commit_rd_o),
        .commit_prd_o      (commit_prd_o),
        .commit_gl_index_o (commit_gl_index_o)
    );

endmodule

/* hw/gl_commit.sv */
// In-order graduation
`timescale 1ns/1ns
`include "rename_defines.svh"

module gl_commit import rename_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  gl_state_t [`GL_DEPTH-1:0] slots_i,
    // Back to the slots
    output logic                      retire_o,
    output gl_index_t                 head_o,
    // Back to the free list
    output logic                      free_valid_o,
    output phys_reg_t                 free_reg_o,
    // Commit report
    output logic                      commit_valid_o,
    output arch_reg_t                 commit_rd_o,
    output phys_reg_t                 commit_prd_o,
    output gl_index_t                 commit_gl_index_o
);

    gl_index_t head_q;
    gl_state_t head_slot;

    assign head_slot = slots_i[head_q];
    assign head_o    = head_q;

    // Oldest entry leaves once it has been written back
    assign retire_o = head_slot.busy & head_slot.done;

    // Only a renamed destination gives its previous register back
    assign free_valid_o = retire_o & head_slot.we;
    assign free_reg_o   = head_slot.old_prd;

    ////////////////////
    // Head pointer

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
        end else if (retire_o) begin
            head_q <= head_q + 1'b1;
        end
    end

    // Commit outputs, one cycle after retirement
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (retire_o) begin
            commit_rd_o       <= head_slot.rd;
            commit_prd_o      <= head_slot.prd;
            commit_gl_index_o <= head_q;
        end
    end

endmodule

/* hw/gl_slot.sv */
// Graduation list entry
`timescale 1ns/1ns
`include "rename_defines.svh"

module gl_slot import rename_pkg::*; #(
    parameter int unsigned SLOT_INDEX = 0
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    gl_alloc_if.sink                  alloc,
    input  logic      [`WB_PORTS-1:0] wb_valid_i,
    input  gl_index_t [`WB_PORTS-1:0] wb_gl_index_i,
    input  logic                      retire_i,
    input  gl_index_t                 head_i,
    output gl_state_t                 state_o
);

    localparam gl_index_t MY_INDEX = gl_index_t'(SLOT_INDEX);

    logic      busy_q;
    logic      done_q;
    arch_reg_t rd_q;
    phys_reg_t prd_q;
    phys_reg_t old_prd_q;
    logic      we_q;
    logic      alloc_hit;
    logic      wb_hit;
    logic      retire_hit;

    assign alloc_hit  = alloc.valid && (alloc.index == MY_INDEX);
    assign retire_hit = retire_i && (head_i == MY_INDEX);

    // Any port may complete this entry
    always_comb begin
        wb_hit = 1'b0;
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_valid_i[p] && (wb_gl_index_i[p] == MY_INDEX)) begin
                wb_hit = 1'b1;
            end
        end
    end

    ////////////////////
    // Entry state

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (alloc_hit) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else begin
                if (retire_hit) begin
                    busy_q <= 1'b0;
                end
                if (wb_hit) begin
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_hit) begin
            rd_q      <= alloc.rd;
            prd_q     <= alloc.prd;
            old_prd_q <= alloc.old_prd;
            we_q      <= alloc.we;
        end
    end

    assign state_o = '{busy: busy_q, done: done_q, rd: rd_q, prd: prd_q,
                       old_prd: old_prd_q, we: we_q};

endmodule

/* hw/rename_map.sv */
// Rename map and graduation tail
`timescale 1ns/1ns
`include "rename_defines.svh"

module rename_map import rename_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // Dispatch
    input  logic                      dispatch_valid_i,
    input  arch_reg_t                 rs1_i,
    input  arch_reg_t                 rs2_i,
    input  arch_reg_t                 rd_i,
    input  logic                      we_i,
    // Writeback
    input  logic      [`WB_PORTS-1:0] wb_valid_i,
    input  phys_reg_t [`WB_PORTS-1:0] wb_prd_i,
    // Retirement
    input  logic                      retire_i,
    input  logic                      free_valid_i,
    input  phys_reg_t                 free_reg_i,
    gl_alloc_if.source                alloc,
    // Rename results
    output logic                      rename_valid_o,
    output phys_reg_t                 prs1_o,
    output phys_reg_t                 prs2_o,
    output phys_reg_t                 prd_o,
    output phys_reg_t                 old_prd_o,
    output logic                      rdy1_o,
    output logic                      rdy2_o,
    output gl_index_t                 gl_index_o,
    output logic                      full_o
);

    localparam int unsigned CNT_W = $clog2(`GL_DEPTH) + 1;

    phys_reg_t                 map_q [`NUM_ARCH_REGS];
    logic [`NUM_PHYS_REGS-1:0] ready_q;
    gl_index_t                 tail_q;
    logic [CNT_W-1:0]          count_q;
    phys_reg_t                 fl_head;
    logic                      accept;
    logic                      alloc_dst;
    phys_reg_t                 prs1;
    phys_reg_t                 prs2;
    phys_reg_t                 old_prd;
    phys_reg_t                 new_prd;
    logic                      rdy1;
    logic                      rdy2;

    // Writeback on this edge for preg
    function automatic logic wb_snoop(input phys_reg_t preg);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_valid_i[p] && (wb_prd_i[p] == preg)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    free_list i_free_list (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .pop_i      (alloc_dst),
        .push_i     (free_valid_i),
        .push_reg_i (free_reg_i),
        .head_o     (fl_head)
    );

    assign full_o    = (count_q == CNT_W'(`GL_DEPTH));
    assign accept    = dispatch_valid_i & ~full_o;
    // x0 never gets a new register
    assign alloc_dst = accept & we_i & (rd_i != '0);

    assign prs1    = map_q[rs1_i];
    assign prs2    = map_q[rs2_i];
    assign old_prd = map_q[rd_i];
    assign new_prd = alloc_dst ? fl_head : old_prd;
    assign rdy1    = (rs1_i == '0) | ready_q[prs1] | wb_snoop(prs1);
    assign rdy2    = (rs2_i == '0) | ready_q[prs2] | wb_snoop(prs2);

    // Slot allocation goes out on the dispatch edge
    assign alloc.valid   = accept;
    assign alloc.index   = tail_q;
    assign alloc.rd      = rd_i;
    assign alloc.prd     = new_prd;
    assign alloc.old_prd = old_prd;
    assign alloc.we      = alloc_dst;

    ////////////////////
    // Map and ready table

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else if (alloc_dst) begin
            map_q[rd_i] <= fl_head;
        end
    end

    // Clearing the new register comes last and wins
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            ready_q <= '1;
        end else begin
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb_valid_i[p]) begin
                    ready_q[wb_prd_i[p]] <= 1'b1;
                end
            end
            if (alloc_dst) begin
                ready_q[fl_head] <= 1'b0;
            end
        end
    end

    ////////////////////
    // Tail and occupancy

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
            if (accept && !retire_i) begin
                count_q <= count_q + 1'b1;
            end else if (!accept && retire_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Registered rename results
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rename_valid_o <= 1'b0;
        end else begin
            rename_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            prs1_o     <= prs1;
            prs2_o     <= prs2;
            prd_o      <= new_prd;
            old_prd_o  <= old_prd;
            rdy1_o     <= rdy1;
            rdy2_o     <= rdy2;
            gl_index_o <= tail_q;
        end
    end

endmodule

/* hw/free_list.sv */
// Physical register free list
`timescale 1ns/1ns
`include "rename_defines.svh"

module free_list import rename_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      pop_i,
    input  logic      push_i,
    input  phys_reg_t push_reg_i,
    output phys_reg_t head_o
);

    localparam int unsigned FL_DEPTH = `NUM_PHYS_REGS - `NUM_ARCH_REGS;
    localparam int unsigned PTR_W    = $clog2(FL_DEPTH);

    phys_reg_t        entries_q [FL_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;

    // Wrap explicitly so a depth that is not a power of two also works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(FL_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Next register handed out at rename
    assign head_o = entries_q[head_q];

    ////////////////////
    // Queue storage

    // Starts full with the registers above the architectural ones
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                entries_q[i] <= phys_reg_t'(`NUM_ARCH_REGS + i);
            end
        end else if (push_i) begin
            entries_q[tail_q] <= push_reg_i;
        end
    end

    // Full at reset, so tail sits on head
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (pop_i) begin
                head_q <= next_ptr(head_q);
            end
            if (push_i) begin
                tail_q <= next_ptr(tail_q);
            end
        end
    end

endmodule

/* hw/gl_alloc_if.sv */
// Graduation list allocation bus
`timescale 1ns/1ns

interface gl_alloc_if import rename_pkg::*; ();

    // One-cycle strobe, addressed by index
    logic      valid;
    gl_index_t index;

    // Instruction payload for the slot
    arch_reg_t rd;
    phys_reg_t prd;
    phys_reg_t old_prd;
    logic      we;

    // Rename map side
    modport source (
        output valid,
        output index,
        output rd,
        output prd,
        output old_prd,
        output we
    );

    // Every slot listens
    modport sink (
        input valid,
        input index,
        input rd,
        input prd,
        input old_prd,
        input we
    );

endinterface

/* hw/rename_pkg.sv */
// Rename block types

package rename_pkg;

    `include "rename_defines.svh"

    // Register numbers
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_reg_t;

    // Graduation list position
    typedef logic [$clog2(`GL_DEPTH)-1:0] gl_index_t;

    ////////////////////
    // Slot contents

    // we is set only when the instruction took a new physical register
    typedef struct packed {
        logic      busy;
        logic      done;
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      we;
    } gl_state_t;

endpackage

/* include/rename_defines.svh */
// Rename block sizes

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural and physical register counts
`define NUM_ARCH_REGS 32
`define NUM_PHYS_REGS 64

// Graduation list entries
`define GL_DEPTH 16

// Writeback ports into the graduation list
`define WB_PORTS 2

`endif
